//--- Bender.yml
package:
  name: qed_store

export_include_dirs:
  - verilog

sources:
  - target: rtl
    include_dirs:
      - verilog
    files:
      - verilog/qed_hcw_pkg.sv
      - verilog/qed_pwr_pkg.sv
      - verilog/qed_rf_16x23.sv
      - verilog/qed_queue_slice.sv
      - verilog/qed_enq_steer.sv
      - verilog/qed_deq_arb.sv
      - verilog/qed_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clkgen.sv
      - test/qed_props.sv
      - test/qed_tb.sv

//--- sources.f
+incdir+verilog
verilog/qed_hcw_pkg.sv
verilog/qed_pwr_pkg.sv
verilog/qed_rf_16x23.sv
verilog/qed_queue_slice.sv
verilog/qed_enq_steer.sv
verilog/qed_deq_arb.sv
verilog/qed_top.sv
test/tb_clkgen.sv
test/qed_props.sv
test/qed_tb.sv

//--- test/qed_props.sv
// --------------------------------------
// Queue-entry store properties
// Pop encoding, producer discipline and
// dequeue against earlier pops
// --------------------------------------

`include "qed_defines.svh"

module qed_props (
     input  logic                                     clk
    ,input  logic                                     rst_n
    ,input  logic [`QED_NUM_QUEUES-1:0]               wr_en
    ,input  logic [`QED_NUM_QUEUES-1:0]               pop
    ,input  logic [`QED_NUM_QUEUES-1:0]               pwr_awake
    ,input  logic                                     deq_valid
    ,input  logic [`QED_NUM_QUEUES-1:0][`QED_RF_AW:0] enq_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions, read by the testbench every cycle
    int fail_cnt = 0;

    logic [`QED_NUM_QUEUES-1:0][`QED_RF_AW:0] pop_cnt;
    logic [`QED_NUM_QUEUES-1:0][`QED_RF_AW:0] occ;

    // Pops per queue, modulo 32 like the enqueue counters in the steer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt <= '0;
        end else begin
            for (int q = 0; q < `QED_NUM_QUEUES; q++) begin
                if (pop[q]) begin
                    pop_cnt[q] <= pop_cnt[q] + 1'b1;
                end
            end
        end
    end

    // The arbiter serves at most one queue per cycle
    a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop))
    else begin
        $error("pop has more than one bit set: %b", pop);
        fail_cnt++;
    end

    for (genvar q = 0; q < `QED_NUM_QUEUES; q++) begin : g_enq
        // Both counters wrap together, so the difference is the fill level
        assign occ[q] = enq_cnt[q] - pop_cnt[q];

        a_enq_ok: assert property (@(posedge clk) disable iff (!rst_n)
            wr_en[q] |-> pwr_awake[q] && (occ[q] < 5'(`QED_RF_DEPTH)))
        else begin
            $error("enqueue to queue %0d while asleep or full", q);
            fail_cnt++;
        end
    end

    // Read data comes one cycle after the pop
    a_deq_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
        deq_valid |-> $past(|pop))
    else begin
        $error("deq_valid without a pop in the cycle before");
        fail_cnt++;
    end

endmodule

bind qed_top qed_props u_props (
     .clk       (clk)
    ,.rst_n     (rst_n)
    ,.wr_en     (wr_en)
    ,.pop       (pop)
    ,.pwr_awake (pwr_awake)
    ,.deq_valid (deq_valid)
    ,.enq_cnt   (u_steer.enq_cnt)
);

//--- test/qed_tb.sv
// --------------------------------------
// Queue-entry store testbench
// LFSR driven producer and consumer, a
// FIFO model per queue, round-robin and
// power sequence checks
// --------------------------------------

`include "qed_defines.svh"

module qed_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int          NQ        = `QED_NUM_QUEUES;

    logic                       clk;
    logic                       rst_n;
    logic                       enq_valid;
    qed_hcw_pkg::qed_enq_t      enq;
    logic                       deq_credit;
    logic [`QED_NUM_QUEUES-1:0] sleep_req;
    logic                       deq_valid;
    qed_hcw_pkg::qed_deq_t      deq;
    logic [`QED_NUM_QUEUES-1:0] enq_credit_return;
    logic [`QED_NUM_QUEUES-1:0] pwr_awake;
    logic [`QED_NUM_QUEUES-1:0] pwr_enable_b_out;

    // Model of the queues, the producer credits and the consumer grants
    qed_hcw_pkg::qed_hcw_t      model_q [NQ][$];
    int                         prod_cred [NQ];
    int                         granted;
    int                         deq_cnt;
    int                         last_qid;
    logic                       rr_mode;
    logic [`QED_NUM_QUEUES-1:0] awake_seen;
    logic [`QED_NUM_QUEUES-1:0] sleep_vec;
    logic [31:0]                lfsr_state;
    // Enqueues driven in this cycle and the one before, not yet visible to the arbiter
    logic [`QED_NUM_QUEUES-1:0] enq_now;
    logic [`QED_NUM_QUEUES-1:0] enq_prev;

    tb_clkgen u_clkgen (
         .clk   (clk)
        ,.rst_n (rst_n)
    );

    qed_top DUT (
         .clk               (clk)
        ,.rst_n             (rst_n)
        ,.enq_valid         (enq_valid)
        ,.enq               (enq)
        ,.deq_credit        (deq_credit)
        ,.sleep_req         (sleep_req)
        ,.deq_valid         (deq_valid)
        ,.deq               (deq)
        ,.enq_credit_return (enq_credit_return)
        ,.pwr_awake         (pwr_awake)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
    );

    // --------------------------------------
    // Random numbers
    // --------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic qed_hcw_pkg::qed_hcw_t rand_hcw();
        qed_hcw_pkg::qed_hcw_t h;
        h.op      = qed_hcw_pkg::qed_op_e'(2'(rand_bits(2)));
        h.flow_id = 5'(rand_bits(5));
        h.payload = 16'(rand_bits(16));
        return h;
    endfunction

    function automatic int model_total();
        int n;
        n = 0;
        for (int q = 0; q < NQ; q++) begin
            n += model_q[q].size();
        end
        return n;
    endfunction

    // The pop behind a dequeue was chosen a cycle earlier, when entries driven
    // in the last two cycles were not stored yet
    // Round-robin takes the first awake queue with a stored entry after the last one served
    function automatic int predict_qid();
        int q;
        for (int i = 1; i <= NQ; i++) begin
            q = (last_qid + i) % NQ;
            if (awake_seen[q] &&
                model_q[q].size() > int'(enq_now[q]) + int'(enq_prev[q])) begin
                return q;
            end
        end
        return -1;
    endfunction

    // --------------------------------------
    // Failure handling and compares
    // --------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_deq(input qed_hcw_pkg::qed_deq_t got,
                             input qed_hcw_pkg::qed_deq_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: deq = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_credit(input logic [`QED_NUM_QUEUES-1:0] got,
                                input logic [`QED_NUM_QUEUES-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: enq_credit_return = %h, expected %h", got, exp));
        end
    endtask

    task automatic check_pwr(input int q, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: pwr_awake[%0d] = %h, expected %h", q, got, exp));
        end
    endtask

    task automatic check_gate(input int q, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: pwr_enable_b_out[%0d] = %h, expected %h",
                                q, got, exp));
        end
    endtask

    // Outputs are looked at on the falling edge, half a cycle after they settle
    task automatic observe();
        qed_hcw_pkg::qed_deq_t      exp_deq;
        logic [`QED_NUM_QUEUES-1:0] exp_ret;
        int                         pq;
        exp_ret = '0;
        if (DUT.u_props.fail_cnt != 0) begin
            abort_run("A property bound into the DUT failed");
        end
        if (deq_valid === 1'b1) begin
            pq = predict_qid();
            if (pq < 0) begin
                abort_run("deq_valid while no awake queue held a stored entry");
            end
            // In round-robin mode every queue holds data, so the next one in turn is served
            exp_deq.qid = rr_mode ? `QED_QID_W'(last_qid + 1) : `QED_QID_W'(pq);
            if (model_q[exp_deq.qid].size() == 0) begin
                abort_run($sformatf("Dequeue from queue %0d, which holds no entry",
                                    exp_deq.qid));
            end
            exp_deq.hcw = model_q[exp_deq.qid].pop_front();
            check_deq(deq, exp_deq);
            exp_ret[exp_deq.qid] = 1'b1;
            deq_cnt++;
            if (deq_cnt > granted) begin
                abort_run("More entries were dequeued than consumer credits were granted");
            end
            prod_cred[exp_deq.qid]++;
            last_qid = exp_deq.qid;
        end else if (deq_valid !== 1'b0) begin
            abort_run("deq_valid is unknown");
        end
        check_credit(enq_credit_return, exp_ret);
        // An awake array has had power applied since at least the cycle before
        for (int q = 0; q < NQ; q++) begin
            if (pwr_awake[q] === 1'b1) begin
                check_gate(q, pwr_enable_b_out[q], 1'b0);
            end
        end
        awake_seen = pwr_awake;
    endtask

    // Each clock drives on the rising edge and checks on the falling edge
    task automatic run_cycle(input logic ev, input logic [`QED_QID_W-1:0] qid,
                             input qed_hcw_pkg::qed_hcw_t hcw, input logic cr);
        @(posedge clk);
        enq_valid  <= ev;
        enq        <= {qid, hcw};
        deq_credit <= cr;
        sleep_req  <= sleep_vec;
        enq_prev   = enq_now;
        enq_now    = '0;
        if (ev) begin
            model_q[qid].push_back(hcw);
            prod_cred[qid]--;
            enq_now[qid] = 1'b1;
        end
        if (cr) begin
            granted++;
        end
        @(negedge clk);
        observe();
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            run_cycle(1'b0, '0, '0, 1'b0);
        end
    endtask

    // Grants are held back once four are outstanding so the DUT counter never saturates
    function automatic logic credit_room();
        return (granted - deq_cnt) < 4;
    endfunction

    // --------------------------------------
    // Traffic and wait loops
    // --------------------------------------
    task automatic random_traffic(input int n);
        logic [`QED_QID_W-1:0] qid;
        logic                  ev;
        logic                  cr;
        for (int i = 0; i < n; i++) begin
            ev  = 1'(rand_bits(1));
            qid = `QED_QID_W'(rand_bits(2));
            // Consumer runs slower than the producer, so queues fill up to their credit
            cr  = (rand_bits(2) == 0) && credit_room();
            if (prod_cred[qid] == 0 || !awake_seen[qid]) begin
                ev = 1'b0;
            end
            run_cycle(ev, qid, rand_hcw(), cr);
        end
    endtask

    // Tops every queue up to the given level without granting consumer credit
    task automatic fill_to(input int level);
        logic [`QED_QID_W-1:0] qid;
        int                    guard;
        guard = 0;
        while (model_total() < level * NQ) begin
            qid = `QED_QID_W'(rand_bits(2));
            while (model_q[qid].size() >= level) begin
                qid = qid + 1'b1;
            end
            run_cycle(1'b1, qid, rand_hcw(), 1'b0);
            guard++;
            if (guard > 4 * level * NQ) begin
                abort_run("Queues could not be filled in time");
            end
        end
    endtask

    task automatic drain(input int limit);
        int guard;
        guard = 0;
        while (model_total() != 0) begin
            run_cycle(1'b0, '0, '0, credit_room());
            guard++;
            if (guard > limit) begin
                abort_run($sformatf("Queues did not drain within %0d cycles", limit));
            end
        end
    endtask

    task automatic wait_awake(input int q, input logic level, input int limit);
        int guard;
        guard = 0;
        while (awake_seen[q] !== level) begin
            run_cycle(1'b0, '0, '0, 1'b0);
            guard++;
            if (guard > limit) begin
                abort_run($sformatf("pwr_awake[%0d] did not become %0b within %0d cycles",
                                    q, level, limit));
            end
        end
    endtask

    // --------------------------------------
    // Test sequence
    // --------------------------------------
    initial begin : main
        int guard;
        int n;
        int target;
        enq_valid  = 1'b0;
        enq        = '0;
        deq_credit = 1'b0;
        sleep_req  = '0;
        sleep_vec  = '0;
        lfsr_state = 32'hac5b_01b9;
        granted    = 0;
        deq_cnt    = 0;
        last_qid   = NQ - 1;
        rr_mode    = 1'b0;
        awake_seen = '0;
        enq_now    = '0;
        enq_prev   = '0;
        for (int q = 0; q < NQ; q++) begin
            prod_cred[q] = `QED_RF_DEPTH;
        end

        guard = 0;
        while (rst_n !== 1'b1) begin
            run_cycle(1'b0, '0, '0, 1'b0);
            guard++;
            if (guard > 20) begin
                abort_run("Reset was never released");
            end
        end
        idle(3);
        for (int q = 0; q < NQ; q++) begin
            check_pwr(q, pwr_awake[q], 1'b1);
        end

        // Entries wait in the queues while no credit has been granted
        fill_to(4);
        idle(50);
        if (deq_cnt != 0) begin
            abort_run("Entries were dequeued while credits were withheld");
        end

        // Fill eight per queue and grant every cycle so the ids must rotate
        fill_to(8);
        rr_mode = 1'b1;
        target  = deq_cnt + 8 * NQ;
        guard   = 0;
        while (deq_cnt < target) begin
            run_cycle(1'b0, '0, '0, 1'b1);
            guard++;
            if (guard > 100) begin
                abort_run("Round-robin drain did not finish in time");
            end
        end
        rr_mode = 1'b0;

        random_traffic(400);
        drain(300);

        // Put an empty queue to sleep and wake it, then send normal traffic through it
        sleep_vec[2] = 1'b1;
        wait_awake(2, 1'b0, 20);
        for (int i = 0; i < 10; i++) begin
            run_cycle(1'b0, '0, '0, 1'b0);
            check_pwr(2, pwr_awake[2], 1'b0);
            // Power goes off once isolation has run for its full time
            if (i >= `QED_PWR_ISOL_CYC) begin
                check_gate(2, pwr_enable_b_out[2], 1'b1);
            end
        end
        sleep_vec[2] = 1'b0;
        wait_awake(2, 1'b1, 20);
        random_traffic(200);
        drain(300);

        // Leftover grants are used up first so six entries stay in queue 1
        n = granted - deq_cnt + 6;
        for (int i = 0; i < n; i++) begin
            run_cycle(1'b1, `QED_QID_W'(1), rand_hcw(), 1'b0);
        end
        guard = 0;
        while (deq_cnt != granted) begin
            run_cycle(1'b0, '0, '0, 1'b0);
            guard++;
            if (guard > 20) begin
                abort_run("Outstanding consumer credits were not used up");
            end
        end
        sleep_vec[1] = 1'b1;
        for (int i = 0; i < 20; i++) begin
            run_cycle(1'b0, '0, '0, 1'b0);
            check_pwr(1, pwr_awake[1], 1'b1);
        end
        guard = 0;
        while (model_q[1].size() != 0) begin
            run_cycle(1'b0, '0, '0, credit_room());
            if (model_q[1].size() != 0) begin
                check_pwr(1, pwr_awake[1], 1'b1);
            end
            guard++;
            if (guard > 100) begin
                abort_run("Queue 1 did not drain while sleep was requested");
            end
        end
        wait_awake(1, 1'b0, 20);
        sleep_vec[1] = 1'b0;
        wait_awake(1, 1'b1, 20);
        random_traffic(200);
        drain(300);

        idle(5);
        if (DUT.u_props.fail_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("A property bound into the DUT failed");
        end
    end

endmodule

//--- test/tb_clkgen.sv
// --------------------------------------
// Testbench clock and reset
// 100 ns clock, rst_n low for 3 cycles
// --------------------------------------

module tb_clkgen (
     output logic clk
    ,output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is released on a rising edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verilog/qed_defines.svh
// --------------------------------------
// Queue-entry store constants
// Sizes of the queue array, the register
// file and the power sequencing timers
// --------------------------------------

`ifndef QED_DEFINES_SVH
`define QED_DEFINES_SVH

// Number of queues and the width of a queue id
`define QED_NUM_QUEUES    4
`define QED_QID_W         2

// Register file geometry, depth is also the initial producer credit count
`define QED_RF_DEPTH      16
`define QED_RF_AW         4

// Consumer credit counter width
`define QED_DEQ_CRED_W    5

// Power sequencing, cycles spent in isolation and in wake
`define QED_PWR_ISOL_CYC  2
`define QED_PWR_WAKE_CYC  4

`endif

//--- verilog/qed_deq_arb.sv
// --------------------------------------
// Dequeue arbiter
// Round-robin pick among awake non-empty
// queues, paced by consumer credits
// --------------------------------------

`include "qed_defines.svh"

module qed_deq_arb (
     input  logic                                             clk
    ,input  logic                                             rst_n
    ,input  qed_pwr_pkg::qed_pwr_stat_t [`QED_NUM_QUEUES-1:0] pwr_stat
    ,output logic [`QED_NUM_QUEUES-1:0]                       pop
    ,input  qed_hcw_pkg::qed_hcw_t [`QED_NUM_QUEUES-1:0]      rd_hcw
    ,input  logic                                             deq_credit
    ,output logic                                             deq_valid
    ,output qed_hcw_pkg::qed_deq_t                            deq
    ,output logic [`QED_NUM_QUEUES-1:0]                       enq_credit_return
);

    logic [`QED_NUM_QUEUES-1:0] elig;
    logic [`QED_QID_W-1:0]      rr_ptr;
    logic [`QED_QID_W-1:0]      idx;
    logic [`QED_QID_W-1:0]      pick_qid;
    logic                       pick_vld;
    logic                       pop_fire;
    logic [`QED_QID_W-1:0]      pop_qid_q;
    logic                       pop_vld_q;
    logic [`QED_DEQ_CRED_W-1:0] cred_cnt;

    // A queue may be served when it holds data and its array is powered
    always_comb begin
        for (int q = 0; q < `QED_NUM_QUEUES; q++) begin
            elig[q] = !pwr_stat[q].empty && pwr_stat[q].awake;
        end
    end

    // Scan from the pointer upwards, the loop runs backwards
    // so the nearest eligible queue wins
    always_comb begin
        pick_vld = 1'b0;
        pick_qid = rr_ptr;
        for (int i = `QED_NUM_QUEUES - 1; i >= 0; i--) begin
            idx = rr_ptr + `QED_QID_W'(i);
            if (elig[idx]) begin
                pick_vld = 1'b1;
                pick_qid = idx;
            end
        end
    end

    assign pop_fire = pick_vld && (cred_cnt != '0);

    always_comb begin
        pop = '0;
        if (pop_fire) begin
            pop[pick_qid] = 1'b1;
        end
    end

    // --------------------------------------
    // Pointer, credits and read stage
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr    <= '0;
            cred_cnt  <= '0;
            pop_vld_q <= 1'b0;
            pop_qid_q <= '0;
        end else begin
            if (pop_fire) begin
                rr_ptr <= pick_qid + 1'b1;
            end
            // A grant in the same cycle as a pop cancels it out
            case ({pop_fire, deq_credit})
                2'b10:   cred_cnt <= cred_cnt - 1'b1;
                2'b01:   cred_cnt <= (cred_cnt == '1) ? cred_cnt : cred_cnt + 1'b1;
                default: cred_cnt <= cred_cnt;
            endcase
            pop_vld_q <= pop_fire;
            if (pop_fire) begin
                pop_qid_q <= pick_qid;
            end
        end
    end

    // The slice read data arrives one cycle after its pop
    assign deq_valid = pop_vld_q;
    assign deq.qid   = pop_qid_q;
    assign deq.hcw   = rd_hcw[pop_qid_q];

    // One producer credit goes back with every dequeued entry
    always_comb begin
        enq_credit_return = '0;
        if (pop_vld_q) begin
            enq_credit_return[pop_qid_q] = 1'b1;
        end
    end

endmodule

//--- verilog/qed_enq_steer.sv
// --------------------------------------
// Enqueue steering
// Turns the queue id of an enqueue into
// the write strobe of one slice
// --------------------------------------

`include "qed_defines.svh"

module qed_enq_steer (
     input  logic                          clk
    ,input  logic                          rst_n
    ,input  logic                          enq_valid
    ,input  qed_hcw_pkg::qed_enq_t         enq
    ,output logic [`QED_NUM_QUEUES-1:0]    wr_en
    ,output qed_hcw_pkg::qed_hcw_t         wr_hcw
);

    // Entries steered into each queue, modulo 32
    // Checkers compare this against the pops of the same queue
    logic [`QED_NUM_QUEUES-1:0][`QED_RF_AW:0] enq_cnt;

    // One-hot strobe, no register stage so the write lands at the accepting edge
    always_comb begin
        wr_en = '0;
        if (enq_valid) begin
            wr_en[enq.qid] = 1'b1;
        end
    end

    // Every slice sees the same entry, only the strobed one stores it
    assign wr_hcw = enq.hcw;

    // --------------------------------------
    // Occupancy bookkeeping for checkers
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_cnt <= '0;
        end else begin
            for (int q = 0; q < `QED_NUM_QUEUES; q++) begin
                if (wr_en[q]) begin
                    enq_cnt[q] <= enq_cnt[q] + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/qed_hcw_pkg.sv
// --------------------------------------
// Queue entry format
// Opcode encoding, the 23-bit entry and
// the enqueue and dequeue transfer types
// --------------------------------------

`include "qed_defines.svh"

package qed_hcw_pkg;

    // Entry opcode, carried in the top two bits of every entry
    typedef enum logic [1:0] {
        OP_NEW   = 2'd0,
        OP_COMP  = 2'd1,
        OP_FRAG  = 2'd2,
        OP_TOKEN = 2'd3
    } qed_op_e;

    // One queue entry, 2 + 5 + 16 = 23 bits
    typedef struct packed {
        qed_op_e       op;
        logic [4:0]    flow_id;
        logic [15:0]   payload;
    } qed_hcw_t;

    // Producer side transfer, the queue id selects the target slice
    typedef struct packed {
        logic [`QED_QID_W-1:0] qid;
        qed_hcw_t              hcw;
    } qed_enq_t;

    // Consumer side transfer, qid names the queue the entry came from
    typedef struct packed {
        logic [`QED_QID_W-1:0] qid;
        qed_hcw_t              hcw;
    } qed_deq_t;

endpackage

//--- verilog/qed_pwr_pkg.sv
// --------------------------------------
// Queue power control types
// Power state encoding and the status
// each slice reports to the arbiter
// --------------------------------------

package qed_pwr_pkg;

    // Power states of one register file
    // ON is the only state where the queue may be read or written
    typedef enum logic [1:0] {
        PWR_ON   = 2'd0,
        PWR_ISOL = 2'd1,
        PWR_OFF  = 2'd2,
        PWR_WAKE = 2'd3
    } qed_pwr_state_e;

    // Per-slice status, empty comes from the fill count
    // and awake is high only in PWR_ON
    typedef struct packed {
        qed_pwr_state_e pwr_state;
        logic           empty;
        logic           awake;
    } qed_pwr_stat_t;

endpackage

//--- verilog/qed_queue_slice.sv
// --------------------------------------
// One queue of the entry store
// FIFO pointers and fill count around a
// register file, plus its power FSM
// --------------------------------------

`include "qed_defines.svh"

module qed_queue_slice #(
    parameter int SLICE_ID = 0
) (
     input  logic                       clk
    ,input  logic                       rst_n
    ,input  logic                       wr_en
    ,input  qed_hcw_pkg::qed_hcw_t      wr_hcw
    ,input  logic                       pop
    ,output qed_hcw_pkg::qed_hcw_t      rd_hcw
    ,input  logic                       sleep_req
    ,output qed_pwr_pkg::qed_pwr_stat_t pwr_stat
    ,output logic                       pwr_enable_b_out
);

    localparam logic [2:0] ISOL_LAST = 3'(`QED_PWR_ISOL_CYC - 1);
    localparam logic [2:0] WAKE_LAST = 3'(`QED_PWR_WAKE_CYC - 1);

    logic [`QED_RF_AW-1:0]       wptr;
    logic [`QED_RF_AW-1:0]       rptr;
    logic [`QED_RF_AW:0]         fill_cnt;
    qed_pwr_pkg::qed_pwr_state_e pwr_state;
    logic [2:0]                  pwr_cnt;
    logic                        sleep_ok;

    // Slice index must name one of the queues
    if (SLICE_ID < 0 || SLICE_ID >= `QED_NUM_QUEUES) begin : g_bad_id
        $error("qed_queue_slice SLICE_ID %0d out of range", SLICE_ID);
    end

    // --------------------------------------
    // FIFO pointers
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr     <= '0;
            rptr     <= '0;
            fill_cnt <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            // A write and a pop in the same cycle leave the count alone
            case ({wr_en, pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // --------------------------------------
    // Power FSM
    // --------------------------------------
    // Sleep is only taken with nothing stored and nothing moving
    assign sleep_ok = sleep_req && (fill_cnt == '0) && !pop && !wr_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_state <= qed_pwr_pkg::PWR_ON;
            pwr_cnt   <= '0;
        end else begin
            case (pwr_state)
                qed_pwr_pkg::PWR_ON: begin
                    if (sleep_ok) begin
                        pwr_state <= qed_pwr_pkg::PWR_ISOL;
                        pwr_cnt   <= ISOL_LAST;
                    end
                end
                qed_pwr_pkg::PWR_ISOL: begin
                    if (pwr_cnt == '0) begin
                        pwr_state <= qed_pwr_pkg::PWR_OFF;
                    end else begin
                        pwr_cnt <= pwr_cnt - 1'b1;
                    end
                end
                qed_pwr_pkg::PWR_OFF: begin
                    if (!sleep_req) begin
                        pwr_state <= qed_pwr_pkg::PWR_WAKE;
                        pwr_cnt   <= WAKE_LAST;
                    end
                end
                default: begin
                    // Wake, power is back and isolation holds until the timer ends
                    if (pwr_cnt == '0) begin
                        pwr_state <= qed_pwr_pkg::PWR_ON;
                    end else begin
                        pwr_cnt <= pwr_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    assign pwr_stat.pwr_state = pwr_state;
    assign pwr_stat.empty     = (fill_cnt == '0);
    assign pwr_stat.awake     = (pwr_state == qed_pwr_pkg::PWR_ON);

    // Isolate in every state but ON, remove power only in OFF
    qed_rf_16x23 u_rf (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.we               (wr_en)
        ,.waddr            (wptr)
        ,.wdata            (wr_hcw)
        ,.re               (pop)
        ,.raddr            (rptr)
        ,.rdata            (rd_hcw)
        ,.isol_en          (pwr_state != qed_pwr_pkg::PWR_ON)
        ,.pwr_enable_b_in  (pwr_state == qed_pwr_pkg::PWR_OFF)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

//--- verilog/qed_rf_16x23.sv
// --------------------------------------
// 16x23 two-port register file model
// Registered read, output isolation and
// power gating of the array contents
// --------------------------------------

`include "qed_defines.svh"

module qed_rf_16x23 (
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   we
    ,input  logic [`QED_RF_AW-1:0]  waddr
    ,input  qed_hcw_pkg::qed_hcw_t  wdata
    ,input  logic                   re
    ,input  logic [`QED_RF_AW-1:0]  raddr
    ,output qed_hcw_pkg::qed_hcw_t  rdata
    // Power interface
    ,input  logic                   isol_en
    ,input  logic                   pwr_enable_b_in
    ,output logic                   pwr_enable_b_out
);

    qed_hcw_pkg::qed_hcw_t mem [`QED_RF_DEPTH];
    qed_hcw_pkg::qed_hcw_t rdata_q;
    logic [1:0]            rst_sync;
    logic                  rst_sync_n;

    // Reset is asserted at once and released two clocks later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_sync_n = rst_sync[1];

    // Array write, contents are lost while the array is powered down
    always_ff @(posedge clk) begin
        if (pwr_enable_b_in) begin
            for (int i = 0; i < `QED_RF_DEPTH; i++) begin
                mem[i] <= 'x;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, data is held until the next read
    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            rdata_q          <= '0;
            pwr_enable_b_out <= 1'b0;
        end else begin
            if (re) begin
                rdata_q <= mem[raddr];
            end
            // Power enable is passed along the chain after one flop
            pwr_enable_b_out <= pwr_enable_b_in;
        end
    end

    // Isolation clamps the output to zero
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

//--- verilog/qed_top.sv
// --------------------------------------
// Queue-entry store top level
// Enqueue steering, four queue slices
// and the round-robin dequeue arbiter
// --------------------------------------

`include "qed_defines.svh"

module qed_top (
     input  logic                          clk
    ,input  logic                          rst_n
    ,input  logic                          enq_valid
    ,input  qed_hcw_pkg::qed_enq_t         enq
    ,input  logic                          deq_credit
    ,input  logic [`QED_NUM_QUEUES-1:0]    sleep_req
    ,output logic                          deq_valid
    ,output qed_hcw_pkg::qed_deq_t         deq
    ,output logic [`QED_NUM_QUEUES-1:0]    enq_credit_return
    ,output logic [`QED_NUM_QUEUES-1:0]    pwr_awake
    ,output logic [`QED_NUM_QUEUES-1:0]    pwr_enable_b_out
);

    logic [`QED_NUM_QUEUES-1:0]                       wr_en;
    qed_hcw_pkg::qed_hcw_t                            wr_hcw;
    logic [`QED_NUM_QUEUES-1:0]                       pop;
    qed_hcw_pkg::qed_hcw_t [`QED_NUM_QUEUES-1:0]      rd_hcw;
    qed_pwr_pkg::qed_pwr_stat_t [`QED_NUM_QUEUES-1:0] pwr_stat;

    qed_enq_steer u_steer (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.enq_valid (enq_valid)
        ,.enq       (enq)
        ,.wr_en     (wr_en)
        ,.wr_hcw    (wr_hcw)
    );

    // One slice per queue, each with its own power sequencing
    for (genvar q = 0; q < `QED_NUM_QUEUES; q++) begin : g_slice
        qed_queue_slice #(
            .SLICE_ID (q)
        ) u_slice (
             .clk              (clk)
            ,.rst_n            (rst_n)
            ,.wr_en            (wr_en[q])
            ,.wr_hcw           (wr_hcw)
            ,.pop              (pop[q])
            ,.rd_hcw           (rd_hcw[q])
            ,.sleep_req        (sleep_req[q])
            ,.pwr_stat         (pwr_stat[q])
            ,.pwr_enable_b_out (pwr_enable_b_out[q])
        );

        assign pwr_awake[q] = pwr_stat[q].awake;
    end

    qed_deq_arb u_arb (
         .clk               (clk)
        ,.rst_n             (rst_n)
        ,.pwr_stat          (pwr_stat)
        ,.pop               (pop)
        ,.rd_hcw            (rd_hcw)
        ,.deq_credit        (deq_credit)
        ,.deq_valid         (deq_valid)
        ,.deq               (deq)
        ,.enq_credit_return (enq_credit_return)
    );

endmodule
